//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ====================
    // Widths
    // ====================

    localparam int XLEN   = 32;  // Data width in bits
    localparam int BYTES  = XLEN / 8;  // Byte lanes per word
    localparam int ADDRW  = 10;  // Byte address width
    localparam int WORDS  = 256;  // RAM depth in words
    localparam int WADDRW = 8;  // Word address width

    // ====================
    // Memory opcodes
    // ====================

    // Bit 2 marks the unsigned load variants
    typedef enum logic [2:0] {
        MEM_B  = 3'd0,  // Signed byte
        MEM_H  = 3'd1,  // Signed halfword
        MEM_W  = 3'd2,  // Word
        MEM_BU = 3'd4,  // Unsigned byte, loads only
        MEM_HU = 3'd5  // Unsigned halfword, loads only
    } mem_op_e;

endpackage

`default_nettype wire

//--- verilog/dp_ram.sv
`default_nettype none

module dp_ram #(
    parameter int DATAW   = 32,
    parameter int SIZE    = 256,
    parameter int BYTEENW = 4
) (
    input  wire                      clk,
    input  wire  [BYTEENW-1:0]       wren,
    input  wire  [$clog2(SIZE)-1:0]  waddr,
    input  wire  [DATAW-1:0]         wdata,
    input  wire  [$clog2(SIZE)-1:0]  raddr,
    output logic [DATAW-1:0]         rdata
);

    localparam int LANEW = DATAW / BYTEENW;  // Bits per write-enable lane

    logic [BYTEENW-1:0][LANEW-1:0] mem [SIZE];

    // Non-blocking update makes a same-cycle read return the old word
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTEENW; i++) begin
            if (wren[i]) begin
                mem[waddr][i] <= wdata[i*LANEW +: LANEW];
            end
        end
        rdata <= mem[raddr];  // Registered read every cycle
    end

endmodule

`default_nettype wire

//--- verilog/store_align.sv
`default_nettype none

module store_align (
    input  wire                         st_fire,
    input  wire  lsu_pkg::mem_op_e      st_op,
    input  wire  [lsu_pkg::ADDRW-1:0]   st_addr,
    input  wire  [lsu_pkg::XLEN-1:0]    st_data,
    output logic [lsu_pkg::BYTES-1:0]   wren,
    output logic [lsu_pkg::WADDRW-1:0]  waddr,
    output logic [lsu_pkg::XLEN-1:0]    wdata
);

    logic [1:0]                offset;
    logic [lsu_pkg::BYTES-1:0] lane_mask;

    assign offset = st_addr[1:0];
    assign waddr  = st_addr[lsu_pkg::ADDRW-1:2];  // Word index into the RAM

    // Copy the low bytes into every lane so the mask alone picks the target
    always_comb begin
        case (st_op)
            lsu_pkg::MEM_B: begin
                wdata     = {lsu_pkg::BYTES{st_data[7:0]}};
                lane_mask = {{(lsu_pkg::BYTES-1){1'b0}}, 1'b1} << offset;
            end
            lsu_pkg::MEM_H: begin
                wdata     = {(lsu_pkg::BYTES/2){st_data[15:0]}};
                lane_mask = {{(lsu_pkg::BYTES-2){1'b0}}, 2'b11} << offset;
            end
            lsu_pkg::MEM_W: begin
                wdata     = st_data;
                lane_mask = '1;
            end
            default: begin
                wdata     = st_data;
                lane_mask = '0;
            end
        endcase
    end

    assign wren = st_fire ? lane_mask : '0;  // Nothing is written unless the store fires

endmodule

`default_nettype wire

//--- verilog/load_extract.sv
`default_nettype none

module load_extract (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        s1_valid,
    input  wire  lsu_pkg::mem_op_e     s1_op,
    input  wire  [1:0]                 s1_offset,
    input  wire                        s1_fault,
    input  wire  [lsu_pkg::XLEN-1:0]   rdata,
    output logic [lsu_pkg::XLEN-1:0]   ld_rsp_data
);

    logic [lsu_pkg::XLEN-1:0] shifted;
    logic [lsu_pkg::XLEN-1:0] extended;

    // Move the addressed byte or halfword down to lane 0
    assign shifted = rdata >> {s1_offset, 3'b000};

    always_comb begin
        case (s1_op)
            lsu_pkg::MEM_B: begin
                extended = {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::MEM_BU: begin
                extended = {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
            end
            lsu_pkg::MEM_H: begin
                extended = {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::MEM_HU: begin
                extended = {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
            end
            lsu_pkg::MEM_W: begin
                extended = shifted;
            end
            default: begin
                extended = '0;
            end
        endcase
    end

    // ====================
    // Response register
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_rsp_data <= '0;
        end else if (s1_valid && !s1_fault) begin
            ld_rsp_data <= extended;
        end else begin
            ld_rsp_data <= '0;  // Faults and idle cycles return zero
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_ctrl.sv
`default_nettype none

module lsu_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        st_valid,
    input  wire  lsu_pkg::mem_op_e     st_op,
    input  wire  [lsu_pkg::ADDRW-1:0]  st_addr,
    input  wire                        ld_valid,
    input  wire  lsu_pkg::mem_op_e     ld_op,
    input  wire  [lsu_pkg::ADDRW-1:0]  ld_addr,
    output logic                       st_fire,
    output logic                       st_done,
    output logic                       st_err,
    output logic                       s1_valid,
    output lsu_pkg::mem_op_e           s1_op,
    output logic [1:0]                 s1_offset,
    output logic                       s1_fault,
    output logic                       ld_rsp_valid,
    output logic                       ld_rsp_err
);

    logic st_fault;
    logic ld_fault;

    // Natural alignment for halfword and word accesses
    function automatic logic misaligned(lsu_pkg::mem_op_e op, logic [1:0] offset);
        logic bad;
        case (op)
            lsu_pkg::MEM_H, lsu_pkg::MEM_HU: bad = offset[0];
            lsu_pkg::MEM_W: bad = |offset;
            default: bad = 1'b0;
        endcase
        return bad;
    endfunction

    // ====================
    // Legality checks
    // ====================

    // Only signed widths are meaningful on the store port
    assign st_fault = !(st_op inside {lsu_pkg::MEM_B, lsu_pkg::MEM_H, lsu_pkg::MEM_W})
                      || misaligned(st_op, st_addr[1:0]);

    assign ld_fault = !(ld_op inside {lsu_pkg::MEM_B, lsu_pkg::MEM_H, lsu_pkg::MEM_W,
                                      lsu_pkg::MEM_BU, lsu_pkg::MEM_HU})
                      || misaligned(ld_op, ld_addr[1:0]);

    assign st_fire = st_valid && !st_fault;  // Write enable for the RAM this cycle

    // ====================
    // Store response
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            st_done <= 1'b0;
            st_err  <= 1'b0;
        end else begin
            st_done <= st_valid;
            st_err  <= st_valid && st_fault;
        end
    end

    // ====================
    // Load pipeline
    // ====================

    // Stage 1 runs alongside the RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_fault <= 1'b0;
        end else begin
            s1_valid <= ld_valid;
            s1_fault <= ld_valid && ld_fault;
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= ld_op;
        s1_offset <= ld_addr[1:0];  // Byte offset for the extractor
    end

    // Stage 2 lines up with the registered load data
    always_ff @(posedge clk) begin
        if (reset) begin
            ld_rsp_valid <= 1'b0;
            ld_rsp_err   <= 1'b0;
        end else begin
            ld_rsp_valid <= s1_valid;
            ld_rsp_err   <= s1_valid && s1_fault;
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
`default_nettype none

module lsu_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         st_valid,
    input  wire  lsu_pkg::mem_op_e      st_op,
    input  wire  [lsu_pkg::ADDRW-1:0]   st_addr,
    input  wire  [lsu_pkg::XLEN-1:0]    st_data,
    output wire                         st_done,
    output wire                         st_err,
    input  wire                         ld_valid,
    input  wire  lsu_pkg::mem_op_e      ld_op,
    input  wire  [lsu_pkg::ADDRW-1:0]   ld_addr,
    output wire                         ld_rsp_valid,
    output wire  [lsu_pkg::XLEN-1:0]    ld_rsp_data,
    output wire                         ld_rsp_err
);

    wire                        st_fire;
    wire [lsu_pkg::BYTES-1:0]   wren;
    wire [lsu_pkg::WADDRW-1:0]  waddr;
    wire [lsu_pkg::XLEN-1:0]    wdata;
    wire [lsu_pkg::XLEN-1:0]    rdata;
    wire                        s1_valid;
    lsu_pkg::mem_op_e           s1_op;
    wire [1:0]                  s1_offset;
    wire                        s1_fault;

    lsu_ctrl ctrl0 (
        .clk          (clk),
        .reset        (reset),
        .st_valid     (st_valid),
        .st_op        (st_op),
        .st_addr      (st_addr),
        .ld_valid     (ld_valid),
        .ld_op        (ld_op),
        .ld_addr      (ld_addr),
        .st_fire      (st_fire),
        .st_done      (st_done),
        .st_err       (st_err),
        .s1_valid     (s1_valid),
        .s1_op        (s1_op),
        .s1_offset    (s1_offset),
        .s1_fault     (s1_fault),
        .ld_rsp_valid (ld_rsp_valid),
        .ld_rsp_err   (ld_rsp_err)
    );

    store_align store_align0 (
        .st_fire (st_fire),
        .st_op   (st_op),
        .st_addr (st_addr),
        .st_data (st_data),
        .wren    (wren),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    dp_ram #(
        .DATAW   (lsu_pkg::XLEN),
        .SIZE    (lsu_pkg::WORDS),
        .BYTEENW (lsu_pkg::BYTES)
    ) ram0 (
        .clk   (clk),
        .wren  (wren),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (ld_addr[lsu_pkg::ADDRW-1:2]),  // Word index of the load
        .rdata (rdata)
    );

    load_extract load_extract0 (
        .clk         (clk),
        .reset       (reset),
        .s1_valid    (s1_valid),
        .s1_op       (s1_op),
        .s1_offset   (s1_offset),
        .s1_fault    (s1_fault),
        .rdata       (rdata),
        .ld_rsp_data (ld_rsp_data)
    );

endmodule

`default_nettype wire

//--- tb/lsu_tb.sv
`default_nettype none

module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_SUB  = 16;  // Byte and halfword store rounds
    localparam int N_RF   = 16;  // Read-first rounds
    localparam int N_RAND = 400;  // Cycles of mixed traffic
    // Upper bound on issued operations over all tests
    localparam int N_OPS = 2 * lsu_pkg::WORDS + 14 * N_SUB + 3 * 32 + 3 * N_RF + 2 * N_RAND;

    logic                       clk;
    logic                       reset;
    logic                       st_valid;
    lsu_pkg::mem_op_e           st_op;
    logic [lsu_pkg::ADDRW-1:0]  st_addr;
    logic [lsu_pkg::XLEN-1:0]   st_data;
    wire                        st_done;
    wire                        st_err;
    logic                       ld_valid;
    lsu_pkg::mem_op_e           ld_op;
    logic [lsu_pkg::ADDRW-1:0]  ld_addr;
    wire                        ld_rsp_valid;
    wire  [lsu_pkg::XLEN-1:0]   ld_rsp_data;
    wire                        ld_rsp_err;

    logic [7:0]  ref_mem [1 << lsu_pkg::ADDRW];  // Byte-wide reference memory
    int          st_due [$];
    logic        st_exp_err [$];
    int          ld_due [$];
    logic [32:0] ld_exp [$];  // Error flag above the data word
    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_start_errors = 0;

    lsu_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .st_valid     (st_valid),
        .st_op        (st_op),
        .st_addr      (st_addr),
        .st_data      (st_data),
        .st_done      (st_done),
        .st_err       (st_err),
        .ld_valid     (ld_valid),
        .ld_op        (ld_op),
        .ld_addr      (ld_addr),
        .ld_rsp_valid (ld_rsp_valid),
        .ld_rsp_data  (ld_rsp_data),
        .ld_rsp_err   (ld_rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ====================
    // Reference model
    // ====================

    function automatic int access_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::MEM_B, lsu_pkg::MEM_BU: return 1;
            lsu_pkg::MEM_H, lsu_pkg::MEM_HU: return 2;
            lsu_pkg::MEM_W: return 4;
            default: return 0;
        endcase
    endfunction

    function automatic logic store_legal(input lsu_pkg::mem_op_e op, input logic [9:0] addr);
        int size;
        size = access_size(op);
        if (op == lsu_pkg::MEM_BU || op == lsu_pkg::MEM_HU || size == 0) begin
            return 1'b0;
        end
        return (addr % size) == 0;
    endfunction

    function automatic logic [32:0] ref_load(input lsu_pkg::mem_op_e op, input logic [9:0] addr);
        int          size;
        logic [31:0] value;
        size = access_size(op);
        if (size == 0 || (addr % size) != 0) begin
            return {1'b1, 32'h0};  // Faulting loads return zero
        end
        value = '0;
        for (int i = 0; i < size; i++) begin
            value[8*i +: 8] = ref_mem[addr + i];
        end
        if ((op == lsu_pkg::MEM_B || op == lsu_pkg::MEM_H) && value[8*size-1]) begin
            for (int i = 8 * size; i < 32; i++) begin
                value[i] = 1'b1;
            end
        end
        return {1'b0, value};
    endfunction

    function automatic lsu_pkg::mem_op_e rand_op(input bit store_side);
        int pick;
        if ($urandom % 10 == 0) begin
            return lsu_pkg::mem_op_e'(3'($urandom));  // Any code, undefined ones included
        end
        pick = store_side ? $urandom % 3 : $urandom % 5;
        case (pick)
            0: return lsu_pkg::MEM_B;
            1: return lsu_pkg::MEM_H;
            2: return lsu_pkg::MEM_W;
            3: return lsu_pkg::MEM_BU;
            default: return lsu_pkg::MEM_HU;
        endcase
    endfunction

    function automatic logic [9:0] rand_addr(input lsu_pkg::mem_op_e op);
        logic [9:0] a;
        int         size;
        a = 10'($urandom % 128);  // Small window so the ports often meet
        size = access_size(op);
        if (size > 1 && $urandom % 8 != 0) begin
            a = a & ~10'(size - 1);
        end
        return a;
    endfunction

    // ====================
    // Stimulus
    // ====================

    task automatic dual_cycle(
        input logic             sv,
        input lsu_pkg::mem_op_e sop,
        input logic [9:0]       sa,
        input logic [31:0]      sd,
        input logic             lv,
        input lsu_pkg::mem_op_e lop,
        input logic [9:0]       la
    );
        @(posedge clk);
        st_valid <= sv;
        st_op    <= sop;
        st_addr  <= sa;
        st_data  <= sd;
        ld_valid <= lv;
        ld_op    <= lop;
        ld_addr  <= la;
        if (lv) begin
            ld_due.push_back(cyc + 3);
            ld_exp.push_back(ref_load(lop, la));  // Taken before this cycle's store lands
        end
        if (sv) begin
            st_due.push_back(cyc + 2);
            st_exp_err.push_back(!store_legal(sop, sa));
            if (store_legal(sop, sa)) begin
                for (int i = 0; i < access_size(sop); i++) begin
                    ref_mem[sa + i] = sd[8*i +: 8];
                end
            end
        end
    endtask

    task automatic store_cycle(
        input lsu_pkg::mem_op_e op,
        input logic [9:0]       a,
        input logic [31:0]      d
    );
        dual_cycle(1'b1, op, a, d, 1'b0, lsu_pkg::MEM_W, '0);
    endtask

    task automatic load_cycle(input lsu_pkg::mem_op_e op, input logic [9:0] a);
        dual_cycle(1'b0, lsu_pkg::MEM_W, '0, '0, 1'b1, op, a);
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        st_valid <= 1'b0;
        ld_valid <= 1'b0;
        while (st_due.size() != 0 || ld_due.size() != 0) begin
            @(negedge clk);
        end
        tests_run++;
        $display("Test %0d %s finished with %0d errors", tests_run, name,
                 errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ====================
    // Response checks
    // ====================

    always @(negedge clk) begin : compare
        logic        st_expected;
        logic        ld_expected;
        logic        exp_err;
        logic [32:0] exp_ld;
        if (!reset) begin
            st_expected = st_due.size() > 0 && st_due[0] == cyc;
            ld_expected = ld_due.size() > 0 && ld_due[0] == cyc;
            checks += 2;
            if (st_done !== st_expected) begin
                $display("** Error: st_done expected %h got %h at cycle %0d", st_expected,
                         st_done, cyc);
                errors++;
            end
            if (st_expected) begin
                void'(st_due.pop_front());
                exp_err = st_exp_err.pop_front();
                checks++;
                if (st_err !== exp_err) begin
                    $display("** Error: st_err expected %h got %h at cycle %0d", exp_err,
                             st_err, cyc);
                    errors++;
                end
            end
            if (ld_rsp_valid !== ld_expected) begin
                $display("** Error: ld_rsp_valid expected %h got %h at cycle %0d", ld_expected,
                         ld_rsp_valid, cyc);
                errors++;
            end
            if (ld_expected) begin
                void'(ld_due.pop_front());
                exp_ld = ld_exp.pop_front();
                checks += 2;
                if (ld_rsp_err !== exp_ld[32]) begin
                    $display("** Error: ld_rsp_err expected %h got %h at cycle %0d", exp_ld[32],
                             ld_rsp_err, cyc);
                    errors++;
                end
                if (ld_rsp_data !== exp_ld[31:0]) begin
                    $display("** Error: ld_rsp_data expected %h got %h at cycle %0d", exp_ld[31:0],
                             ld_rsp_data, cyc);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(N_OPS * 40 + 2000);
        $display("Timeout: the run did not finish in the time allowed for %0d operations", N_OPS);
        $display("FAIL: see errors above");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================

    initial begin : main
        int               seed;
        lsu_pkg::mem_op_e op;
        lsu_pkg::mem_op_e lop;
        logic [9:0]       a;
        logic [7:0]       w;
        logic [1:0]       off;
        seed = 32'h3fc7;
        void'($urandom(seed));
        reset    = 1'b1;
        st_valid = 1'b0;
        st_op    = lsu_pkg::MEM_W;
        st_addr  = '0;
        st_data  = '0;
        ld_valid = 1'b0;
        ld_op    = lsu_pkg::MEM_W;
        ld_addr  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int k = 0; k < lsu_pkg::WORDS; k++) begin
            store_cycle(lsu_pkg::MEM_W, 10'(k * 4), $urandom);
        end
        for (int k = 0; k < lsu_pkg::WORDS; k++) begin
            load_cycle(lsu_pkg::MEM_W, 10'(k * 4));
        end
        end_test("word round trip");

        for (int n = 0; n < N_SUB; n++) begin
            w   = 8'($urandom);
            op  = ($urandom % 2) ? lsu_pkg::MEM_H : lsu_pkg::MEM_B;
            off = 2'($urandom) & ((op == lsu_pkg::MEM_H) ? 2'b10 : 2'b11);
            store_cycle(op, {w, off}, $urandom);
            load_cycle(lsu_pkg::MEM_W, {w, 2'b00});  // Only the covered bytes may change
            for (int k = 0; k < 4; k++) begin
                load_cycle(lsu_pkg::MEM_B, {w, 2'(k)});
                load_cycle(lsu_pkg::MEM_BU, {w, 2'(k)});
            end
            for (int k = 0; k < 4; k += 2) begin
                load_cycle(lsu_pkg::MEM_H, {w, 2'(k)});
                load_cycle(lsu_pkg::MEM_HU, {w, 2'(k)});
            end
        end
        end_test("byte and halfword access");

        // Every code at every offset on both ports, then a word load of the target
        for (int code = 0; code < 8; code++) begin
            for (int k = 0; k < 4; k++) begin
                op = lsu_pkg::mem_op_e'(3'(code));
                a  = {8'($urandom), 2'(k)};
                dual_cycle(1'b1, op, a, $urandom, 1'b1, op, a);
                load_cycle(lsu_pkg::MEM_W, {a[9:2], 2'b00});
            end
        end
        end_test("faults");

        for (int n = 0; n < N_RF; n++) begin
            a = {8'($urandom), 2'b00};
            dual_cycle(1'b1, lsu_pkg::MEM_W, a, $urandom, 1'b1, lsu_pkg::MEM_W, a);
            load_cycle(lsu_pkg::MEM_W, a);  // Next cycle sees the new word
        end
        end_test("read-first");

        for (int n = 0; n < N_RAND; n++) begin
            op  = rand_op(1'b1);
            a   = rand_addr(op);
            lop = rand_op(1'b0);
            dual_cycle($urandom % 4 != 0, op, a, $urandom, $urandom % 4 != 0,
                       lop, rand_addr(lop));
        end
        end_test("random mixed traffic");

        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/lsu_pkg.sv
verilog/dp_ram.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/lsu_ctrl.sv
verilog/lsu_top.sv
tb/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - verilog/lsu_pkg.sv
  - verilog/dp_ram.sv
  - verilog/store_align.sv
  - verilog/load_extract.sv
  - verilog/lsu_ctrl.sv
  - verilog/lsu_top.sv
  - target: test
    files:
      - tb/lsu_tb.sv
